//--- dv/fpu_aux_checker.sv
`timescale 1ns/10ps
`include "fpu_aux_cfg.svh"

module fpu_aux_checker import fpu_aux_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         fp_v_i,
  input  fpu_aux_req_s req_i,
  input  logic         ready_i,
  input  logic         v_i,
  input  logic [31:0]  result_i,
  input  fflags_s      fflags_i,
  input  logic [2:0]   test_id_i,
  input  logic         test_done_i,
  output int           pending_o,
  output int           checks_o,
  output int           errors_o
);

  fpu_aux_req_s req_q[$];
  int           acc_q[$];
  fpu_aux_req_s head;
  int           acc;
  int           cycle = 0;
  int           since_rst = 0;
  logic         cvt_busy = 1'b0;
  int           pending = 0;
  int           test_checks = 0;
  int           test_errors = 0;
  int           total_checks = 0;
  int           total_errors = 0;
  logic [36:0]  expv;
  int           shifts;
  int           exp_gap;

  assign pending_o = pending;
  assign checks_o  = total_checks;
  assign errors_o  = total_errors;

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd0:    return "reset";
      3'd1:    return "sign_inject_fmv";
      3'd2:    return "min_max";
      3'd3:    return "convert_random";
      3'd4:    return "convert_edges";
      default: return "back_pressure";
    endcase
  endfunction

  function automatic logic is_conversion(input fpu_aux_req_s r);
    return (r.op == OP_FCVT_S_W) || (r.op == OP_FCVT_S_WU);
  endfunction

  // Every negative value, -0 included, gets a smaller key than every positive one.
  function automatic longint order_key(input logic [31:0] x);
    longint k;
    k = {33'd0, x[30:0]};
    if (x[31]) k = -k - 1;
    return k;
  endfunction

  function automatic logic [36:0] model_simple(input fpu_aux_req_s r);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        a_nan;
    logic        b_nan;
    logic        inv;
    a = r.rs1;
    b = r.rs2;
    inv = 1'b0;
    a_nan = (a[30:23] == 8'hFF) && (a[22:0] != 0);
    b_nan = (b[30:23] == 8'hFF) && (b[22:0] != 0);
    case (r.op)
      OP_FSGNJ:  res = {b[31], a[30:0]};
      OP_FSGNJN: res = {~b[31], a[30:0]};
      OP_FSGNJX: res = {a[31] ^ b[31], a[30:0]};
      OP_FMIN, OP_FMAX: begin
        inv = (a_nan && !a[22]) || (b_nan && !b[22]);
        if (a_nan && b_nan) res = `FP_CANON_NAN;
        else if (a_nan) res = b;
        else if (b_nan) res = a;
        else if (r.op == OP_FMIN) res = (order_key(a) < order_key(b)) ? a : b;
        else res = (order_key(a) > order_key(b)) ? a : b;
      end
      default: res = a;
    endcase
    return {inv, 4'b0000, res};
  endfunction

  // The conversion keeps 24 bits from the leading one down, then rounds on what was dropped.
  function automatic logic [36:0] model_cvt(input fpu_aux_req_s r, output int nshift);
    logic        sign;
    logic [31:0] mag;
    logic [63:0] kept;
    logic [63:0] rem;
    logic        guard;
    logic        sticky;
    logic        up;
    int          p;
    int          sh;
    int          e;
    int          i;
    sign = (r.op == OP_FCVT_S_W) && r.rs1[31];
    mag = sign ? (~r.rs1 + 32'd1) : r.rs1;
    nshift = 0;
    if (mag == 0) return 37'd0;
    p = 0;
    for (i = 0; i < 32; i++) if (mag[i]) p = i;
    nshift = 31 - p;
    guard = 1'b0;
    sticky = 1'b0;
    if (p <= 23) begin
      kept = {32'd0, mag} << (23 - p);
    end else begin
      sh = p - 23;
      kept = {32'd0, mag} >> sh;
      rem = {32'd0, mag} & ((64'd1 << sh) - 64'd1);
      guard = rem[sh-1];
      sticky = (rem & ((64'd1 << (sh - 1)) - 64'd1)) != 0;
    end
    case (r.rm)
      RNE:     up = guard && (sticky || kept[0]);
      RDN:     up = sign && (guard || sticky);
      RUP:     up = !sign && (guard || sticky);
      RMM:     up = guard;
      default: up = 1'b0;
    endcase
    kept = kept + up;
    e = 127 + p;
    if (kept[24]) begin
      kept = kept >> 1;
      e = e + 1;
    end
    return {4'b0000, guard || sticky, sign, e[7:0], kept[22:0]};
  endfunction

  task automatic flag_failure(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    test_errors++;
    total_errors++;
  endtask

  task automatic compare_field(input string name, input logic [31:0] want,
                               input logic [31:0] got);
    if (want !== got) begin
      $display("MISMATCH at %0t: %s expected %h got %h", $time, name, want, got);
      test_errors++;
      total_errors++;
    end
  endtask

  always @(posedge clk_i) begin
    cycle++;
    if (rst_i) begin
      since_rst = 0;
      cvt_busy = 1'b0;
    end else begin
      since_rst++;
      // The controller raises ready one cycle after reset is released.
      if (since_rst == 2) begin
        test_checks++;
        total_checks++;
        compare_field("ready_o", 32'd1, {31'd0, ready_i});
        compare_field("v_o", 32'd0, {31'd0, v_i});
      end
      if (cvt_busy && ready_i && !v_i) flag_failure("ready_o is high during a conversion");
      if (v_i) begin
        if (req_q.size() == 0) begin
          flag_failure("v_o pulsed with no accepted request outstanding");
        end else begin
          head = req_q.pop_front();
          acc = acc_q.pop_front();
          pending--;
          if (is_conversion(head)) begin
            expv = model_cvt(head, shifts);
            exp_gap = shifts + 3;
            cvt_busy = 1'b0;
          end else begin
            expv = model_simple(head);
            exp_gap = 1;
          end
          test_checks++;
          total_checks++;
          compare_field("result_o", expv[31:0], result_i);
          compare_field("fflags_o", {27'd0, expv[36:32]}, {27'd0, fflags_i});
          if (cycle - acc != exp_gap) begin
            flag_failure($sformatf("v_o came %0d samples after acceptance instead of %0d",
                                   cycle - acc, exp_gap));
          end
        end
      end
      if (fp_v_i && ready_i) begin
        req_q.push_back(req_i);
        acc_q.push_back(cycle);
        pending++;
        if (is_conversion(req_i)) cvt_busy = 1'b1;
      end
      if (test_done_i) begin
        $display("%s: %0d checks, %0d errors", test_name(test_id_i), test_checks,
                 test_errors);
        test_checks = 0;
        test_errors = 0;
      end
    end
  end

endmodule

//--- dv/fpu_aux_tb.sv
`timescale 1ns/10ps

module fpu_aux_tb import fpu_aux_pkg::*; ();

  localparam int READY_TIMEOUT = 64;
  localparam int DRAIN_TIMEOUT = 200;

  logic         clk;
  logic         rst;
  logic         fp_v;
  fpu_aux_req_s req;
  logic         ready;
  logic         v;
  logic [31:0]  result;
  fflags_s      fflags;
  logic [2:0]   test_id;
  logic         test_done;
  logic         offer_junk;
  int           pending;
  int           checks;
  int           errors;
  integer       seed;

  fpu_aux_top dut0 (
    .clk_i    (clk),
    .rst_i    (rst),
    .fp_v_i   (fp_v),
    .req_i    (req),
    .ready_o  (ready),
    .v_o      (v),
    .result_o (result),
    .fflags_o (fflags)
  );

  fpu_aux_checker chk0 (
    .clk_i       (clk),
    .rst_i       (rst),
    .fp_v_i      (fp_v),
    .req_i       (req),
    .ready_i     (ready),
    .v_i         (v),
    .result_i    (result),
    .fflags_i    (fflags),
    .test_id_i   (test_id),
    .test_done_i (test_done),
    .pending_o   (pending),
    .checks_o    (checks),
    .errors_o    (errors)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // A quarter of the operands are zeros, NaNs, infinities or small integers.
  function automatic logic [31:0] rand_operand();
    logic [31:0] u;
    logic [31:0] w;
    u = $random(seed);
    w = $random(seed);
    if (w[1:0] == 2'd0) begin
      case (w[4:2])
        3'd0:    return 32'h0000_0000;
        3'd1:    return 32'h8000_0000;
        3'd2:    return 32'h7FC0_0000;
        3'd3:    return 32'h7F80_0001;
        3'd4:    return 32'hFFA0_0000;
        3'd5:    return 32'h7F80_0000;
        3'd6:    return 32'hFF80_0000;
        default: return 32'h0000_0001;
      endcase
    end
    if (w[2]) return u >> w[12:8];
    return u;
  endfunction

  function automatic fpu_aux_req_s random_req(input int kind);
    fpu_aux_req_s r;
    logic [31:0]  u;
    logic [2:0]   rm;
    u = $random(seed);
    case (kind)
      0:       r.op = fpu_aux_op_e'(3'd2 + {1'b0, u[1:0]});
      1:       r.op = fpu_aux_op_e'({2'b00, u[0]});
      2:       r.op = fpu_aux_op_e'(3'd6 + {2'b00, u[0]});
      default: r.op = fpu_aux_op_e'(u[2:0]);
    endcase
    rm = u[10:8] % 3'd5;
    r.rm = frm_e'(rm);
    r.rs1 = rand_operand();
    r.rs2 = rand_operand();
    return r;
  endfunction

  function automatic logic [31:0] edge_operand(input int i);
    case (i)
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0001;
      2:       return 32'h8000_0000;
      3:       return 32'hFFFF_FFFF;
      4:       return 32'h7FFF_FFFF;
      5:       return 32'h00FF_FFFF;
      6:       return 32'h0100_0001;
      default: return 32'hFFFF_FF7F;
    endcase
  endfunction

  task automatic abort_run(input string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    $display("TEST FAIL");
    $finish;
  endtask

  // While ready is low, junk requests may be offered; the DUT must drop them.
  task automatic send(input fpu_aux_req_s r);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!ready && waited < READY_TIMEOUT) begin
      fp_v = offer_junk;
      if (offer_junk) req = random_req(3);
      waited++;
      @(negedge clk);
    end
    if (ready) begin
      fp_v = 1'b1;
      req = r;
    end else begin
      abort_run("ready_o to go high");
    end
  endtask

  task automatic finish_test();
    int waited;
    waited = 0;
    @(negedge clk);
    fp_v = 1'b0;
    while (pending != 0 && waited < DRAIN_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (pending != 0) abort_run("outstanding results");
    test_done = 1'b1;
    @(negedge clk);
    test_done = 1'b0;
    test_id = test_id + 3'd1;
  endtask

  initial begin
    fpu_aux_req_s r;
    int           waited;
    int           i;
    int           k;
    int           m;
    seed = 85;
    rst = 1'b1;
    fp_v = 1'b0;
    req = '0;
    test_id = 3'd0;
    test_done = 1'b0;
    offer_junk = 1'b0;
    waited = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (!ready && waited < 8) begin
      @(negedge clk);
      waited++;
    end
    if (!ready) abort_run("ready_o after reset");
    finish_test();

    repeat (200) send(random_req(0));
    finish_test();
    repeat (200) send(random_req(1));
    finish_test();
    repeat (300) send(random_req(2));
    finish_test();

    for (i = 0; i < 8; i++) begin
      for (k = 0; k < 2; k++) begin
        for (m = 0; m < 5; m++) begin
          r.op = k ? OP_FCVT_S_WU : OP_FCVT_S_W;
          r.rm = frm_e'(m[2:0]);
          r.rs1 = edge_operand(i);
          r.rs2 = '0;
          send(r);
        end
      end
    end
    finish_test();

    offer_junk = 1'b1;
    repeat (200) send(random_req(3));
    offer_junk = 1'b0;
    finish_test();

    $display("summary: 6 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- fpu_aux.f
+incdir+logic
logic/fpu_aux_pkg.sv
logic/fpu_fmin_fmax.sv
logic/fpu_i2f_norm.sv
logic/fpu_exp_counter.sv
logic/fpu_aux_ctrl.sv
logic/fpu_float_aux.sv
logic/fpu_aux_top.sv
dv/fpu_aux_checker.sv
dv/fpu_aux_tb.sv

//--- logic/fpu_aux_cfg.svh
`ifndef FPU_AUX_CFG_SVH
`define FPU_AUX_CFG_SVH

// Binary32 format constants.
`define FP_DATA_W 32
`define FP_EXP_W 8
`define FP_MAN_W 23
`define FP_BIAS 127

// Quiet NaN returned when no operand can be passed through.
`define FP_CANON_NAN 32'h7FC0_0000

`endif

//--- logic/fpu_aux_ctrl.sv
`timescale 1ns/10ps

module fpu_aux_ctrl import fpu_aux_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        fp_v_i,
  input  fpu_aux_op_e op_i,
  input  logic        cvt_done_i,
  output logic        ready_o,
  output logic        simple_v_o,
  output logic        cvt_start_o,
  output logic        norm_step_o,
  output logic        round_en_o,
  output logic        cnt_load_o,
  output logic        cnt_dec_o,
  output logic        cvt_v_o
);

  fpu_aux_state_e state_q;
  fpu_aux_state_e state_d;
  logic           ready_q;
  logic           accept;
  logic           is_cvt;

  assign is_cvt = (op_i == OP_FCVT_S_W) || (op_i == OP_FCVT_S_WU);
  assign accept = fp_v_i && ready_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:  if (accept && is_cvt) state_d = ST_NORM;
      ST_NORM:  if (cvt_done_i) state_d = ST_ROUND;
      ST_ROUND: state_d = ST_IDLE;
      default:  state_d = ST_IDLE;
    endcase
  end

  // Ready is registered so that it stays low through reset and rises one cycle later.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      ready_q <= 1'b0;
    end else begin
      state_q <= state_d;
      ready_q <= (state_d == ST_IDLE);
    end
  end

  assign ready_o     = ready_q;
  assign simple_v_o  = accept && !is_cvt;
  assign cvt_start_o = accept && is_cvt;
  assign cnt_load_o  = cvt_start_o;
  assign norm_step_o = (state_q == ST_NORM) && !cvt_done_i;
  assign cnt_dec_o   = norm_step_o;
  assign round_en_o  = (state_q == ST_ROUND);
  assign cvt_v_o     = (state_q == ST_ROUND);

  a_busy_not_ready: assert property (
    @(posedge clk_i) disable iff (rst_i)
    !((state_q == ST_NORM) && ready_o)
  );

  a_one_strobe: assert property (
    @(posedge clk_i) disable iff (rst_i)
    !(simple_v_o && cvt_v_o)
  );

endmodule

//--- logic/fpu_aux_pkg.sv
`include "fpu_aux_cfg.svh"

package fpu_aux_pkg;

  typedef enum logic [2:0] {
    OP_FMIN      = 3'd0,
    OP_FMAX      = 3'd1,
    OP_FSGNJ     = 3'd2,
    OP_FSGNJN    = 3'd3,
    OP_FSGNJX    = 3'd4,
    OP_FMV_W_X   = 3'd5,
    OP_FCVT_S_W  = 3'd6,
    OP_FCVT_S_WU = 3'd7
  } fpu_aux_op_e;

  // Encodings follow the RISC-V frm field.
  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1,
    RDN = 3'd2,
    RUP = 3'd3,
    RMM = 3'd4
  } frm_e;

  // First member lands in the MSB, which matches the NV..NX order of fflags.
  typedef struct packed {
    logic invalid;
    logic div_zero;
    logic overflow;
    logic underflow;
    logic inexact;
  } fflags_s;

  typedef struct packed {
    fpu_aux_op_e          op;
    frm_e                 rm;
    logic [`FP_DATA_W-1:0] rs1;
    logic [`FP_DATA_W-1:0] rs2;
  } fpu_aux_req_s;

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_NORM  = 2'd1,
    ST_ROUND = 2'd2
  } fpu_aux_state_e;

endpackage

//--- logic/fpu_aux_top.sv
`timescale 1ns/10ps
`include "fpu_aux_cfg.svh"

module fpu_aux_top import fpu_aux_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  fp_v_i,
  input  fpu_aux_req_s          req_i,
  output logic                  ready_o,
  output logic                  v_o,
  output logic [`FP_DATA_W-1:0] result_o,
  output fflags_s               fflags_o
);

  logic                  simple_v;
  logic                  cvt_start;
  logic                  norm_step;
  logic                  round_en;
  logic                  cnt_load;
  logic                  cnt_dec;
  logic                  cvt_v;
  logic                  cvt_done;
  logic [`FP_EXP_W-1:0]  cvt_exp;
  logic                  fa_v;
  logic [`FP_DATA_W-1:0] fa_result;
  fflags_s               fa_fflags;
  logic                  norm_v;
  logic [`FP_DATA_W-1:0] norm_result;
  fflags_s               norm_fflags;

  fpu_aux_ctrl ctrl0 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .fp_v_i      (fp_v_i),
    .op_i        (req_i.op),
    .cvt_done_i  (cvt_done),
    .ready_o     (ready_o),
    .simple_v_o  (simple_v),
    .cvt_start_o (cvt_start),
    .norm_step_o (norm_step),
    .round_en_o  (round_en),
    .cnt_load_o  (cnt_load),
    .cnt_dec_o   (cnt_dec),
    .cvt_v_o     (cvt_v)
  );

  fpu_exp_counter cnt0 (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .load_i (cnt_load),
    .dec_i  (cnt_dec),
    .exp_o  (cvt_exp)
  );

  fpu_i2f_norm norm0 (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .start_i  (cvt_start),
    .signed_i (req_i.op == OP_FCVT_S_W),
    .rs1_i    (req_i.rs1),
    .rm_i     (req_i.rm),
    .step_i   (norm_step),
    .round_i  (round_en),
    .exp_i    (cvt_exp),
    .done_o   (cvt_done),
    .v_i      (cvt_v),
    .v_o      (norm_v),
    .result_o (norm_result),
    .fflags_o (norm_fflags)
  );

  fpu_float_aux aux0 (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .v_i      (simple_v),
    .req_i    (req_i),
    .v_o      (fa_v),
    .result_o (fa_result),
    .fflags_o (fa_fflags)
  );

  // The two result strobes never overlap, so the normalizer's strobe alone picks the source.
  assign v_o      = fa_v || norm_v;
  assign result_o = norm_v ? norm_result : fa_result;
  assign fflags_o = norm_v ? norm_fflags : fa_fflags;

endmodule

//--- logic/fpu_exp_counter.sv
`timescale 1ns/10ps
`include "fpu_aux_cfg.svh"

module fpu_exp_counter (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 load_i,
  input  logic                 dec_i,
  output logic [`FP_EXP_W-1:0] exp_o
);

  // Exponent of a value whose leading one sits in bit 31.
  localparam logic [`FP_EXP_W-1:0] EXP_LOAD = `FP_BIAS + 31;
  localparam logic [`FP_EXP_W-1:0] EXP_MIN  = `FP_BIAS;

  logic [`FP_EXP_W-1:0] exp_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exp_q <= '0;
    end else if (load_i) begin
      exp_q <= EXP_LOAD;
    end else if (dec_i) begin
      exp_q <= exp_q - 1'b1;
    end
  end

  assign exp_o = exp_q;

  // At most 31 shifts happen, since a nonzero magnitude has a one somewhere.
  a_no_underrun: assert property (
    @(posedge clk_i) disable iff (rst_i)
    dec_i |-> (exp_q > EXP_MIN)
  );

endmodule

//--- logic/fpu_float_aux.sv
`timescale 1ns/10ps
`include "fpu_aux_cfg.svh"

module fpu_float_aux import fpu_aux_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  v_i,
  input  fpu_aux_req_s          req_i,
  output logic                  v_o,
  output logic [`FP_DATA_W-1:0] result_o,
  output fflags_s               fflags_o
);

  localparam int SIGN_BIT = `FP_DATA_W - 1;

  logic                  minmax_invalid;
  logic [`FP_DATA_W-1:0] minmax_result;
  logic                  sgnj_sign;
  logic [`FP_DATA_W-1:0] result_d;
  fflags_s               fflags_d;

  fpu_fmin_fmax minmax0 (
    .a_i           (req_i.rs1),
    .b_i           (req_i.rs2),
    .min_not_max_i (req_i.op == OP_FMIN),
    .invalid_o     (minmax_invalid),
    .result_o      (minmax_result)
  );

  always_comb begin
    case (req_i.op)
      OP_FSGNJ:  sgnj_sign = req_i.rs2[SIGN_BIT];
      OP_FSGNJN: sgnj_sign = !req_i.rs2[SIGN_BIT];
      OP_FSGNJX: sgnj_sign = req_i.rs1[SIGN_BIT] ^ req_i.rs2[SIGN_BIT];
      default:   sgnj_sign = req_i.rs1[SIGN_BIT];
    endcase
  end

  // Only min/max can raise a flag here.
  always_comb begin
    fflags_d = '0;
    case (req_i.op)
      OP_FMIN, OP_FMAX: begin
        result_d         = minmax_result;
        fflags_d.invalid = minmax_invalid;
      end
      OP_FSGNJ, OP_FSGNJN, OP_FSGNJX: result_d = {sgnj_sign, req_i.rs1[SIGN_BIT-1:0]};
      default: result_d = req_i.rs1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      result_o <= result_d;
      fflags_o <= fflags_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      v_o <= 1'b0;
    end else begin
      v_o <= v_i;
    end
  end

endmodule

//--- logic/fpu_fmin_fmax.sv
`timescale 1ns/10ps
`include "fpu_aux_cfg.svh"

module fpu_fmin_fmax (
  input  logic [`FP_DATA_W-1:0] a_i,
  input  logic [`FP_DATA_W-1:0] b_i,
  input  logic                  min_not_max_i,
  output logic                  invalid_o,
  output logic [`FP_DATA_W-1:0] result_o
);

  localparam int SIGN_BIT = `FP_DATA_W - 1;

  logic a_exp_ones;
  logic b_exp_ones;
  logic a_nan;
  logic b_nan;
  logic a_snan;
  logic b_snan;
  logic a_lt_b;

  assign a_exp_ones = &a_i[SIGN_BIT-1 -: `FP_EXP_W];
  assign b_exp_ones = &b_i[SIGN_BIT-1 -: `FP_EXP_W];
  assign a_nan = a_exp_ones && (a_i[`FP_MAN_W-1:0] != '0);
  assign b_nan = b_exp_ones && (b_i[`FP_MAN_W-1:0] != '0);

  // The quiet bit is the top mantissa bit.
  assign a_snan = a_nan && !a_i[`FP_MAN_W-1];
  assign b_snan = b_nan && !b_i[`FP_MAN_W-1];

  // Sign-magnitude compare.
  // Differing signs also order -0 below +0.
  always_comb begin
    if (a_i[SIGN_BIT] != b_i[SIGN_BIT]) begin
      a_lt_b = a_i[SIGN_BIT];
    end else if (a_i[SIGN_BIT]) begin
      a_lt_b = a_i[SIGN_BIT-1:0] > b_i[SIGN_BIT-1:0];
    end else begin
      a_lt_b = a_i[SIGN_BIT-1:0] < b_i[SIGN_BIT-1:0];
    end
  end

  always_comb begin
    if (a_nan && b_nan) begin
      result_o = `FP_CANON_NAN;
    end else if (a_nan) begin
      result_o = b_i;
    end else if (b_nan) begin
      result_o = a_i;
    end else if (min_not_max_i) begin
      result_o = a_lt_b ? a_i : b_i;
    end else begin
      result_o = a_lt_b ? b_i : a_i;
    end
  end

  assign invalid_o = a_snan || b_snan;

endmodule

//--- logic/fpu_i2f_norm.sv
`timescale 1ns/10ps
`include "fpu_aux_cfg.svh"

module fpu_i2f_norm import fpu_aux_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  start_i,
  input  logic                  signed_i,
  input  logic [`FP_DATA_W-1:0] rs1_i,
  input  frm_e                  rm_i,
  input  logic                  step_i,
  input  logic                  round_i,
  input  logic [`FP_EXP_W-1:0]  exp_i,
  output logic                  done_o,
  input  logic                  v_i,
  output logic                  v_o,
  output logic [`FP_DATA_W-1:0] result_o,
  output fflags_s               fflags_o
);

  logic                  sign_q;
  frm_e                  rm_q;
  logic [`FP_DATA_W-1:0] mag_q;
  logic                  mag_zero;
  logic                  lsb;
  logic                  guard;
  logic                  sticky;
  logic                  round_up;
  logic [`FP_MAN_W+1:0]  sum;
  logic [`FP_EXP_W-1:0]  exp_rnd;
  logic [`FP_DATA_W-1:0] result_d;

  // Sign and magnitude are captured at acceptance, then shifted up until bit 31 is set.
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      sign_q <= signed_i && rs1_i[`FP_DATA_W-1];
      mag_q  <= (signed_i && rs1_i[`FP_DATA_W-1]) ? -rs1_i : rs1_i;
      rm_q   <= rm_i;
    end else if (step_i) begin
      mag_q <= mag_q << 1;
    end
  end

  assign mag_zero = (mag_q == '0);
  assign done_o   = mag_q[`FP_DATA_W-1] || mag_zero;

  // 24 significant bits are kept; bit 7 is the guard bit.
  assign lsb    = mag_q[8];
  assign guard  = mag_q[7];
  assign sticky = |mag_q[6:0];

  always_comb begin
    case (rm_q)
      RNE:     round_up = guard && (sticky || lsb);
      RTZ:     round_up = 1'b0;
      RDN:     round_up = sign_q && (guard || sticky);
      RUP:     round_up = !sign_q && (guard || sticky);
      RMM:     round_up = guard;
      default: round_up = 1'b0;
    endcase
  end

  assign sum = {1'b0, mag_q[`FP_DATA_W-1:8]} + {{(`FP_MAN_W+1){1'b0}}, round_up};

  // A carry leaves the fraction at zero and moves up one binade.
  assign exp_rnd = exp_i + {{(`FP_EXP_W-1){1'b0}}, sum[`FP_MAN_W+1]};

  assign result_d = mag_zero ? '0 : {sign_q, exp_rnd, sum[`FP_MAN_W-1:0]};

  always_ff @(posedge clk_i) begin
    if (round_i) begin
      result_o <= result_d;
      fflags_o <= '{invalid: 1'b0, div_zero: 1'b0, overflow: 1'b0, underflow: 1'b0,
                    inexact: guard || sticky};
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      v_o <= 1'b0;
    end else begin
      v_o <= v_i;
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and reports the outcome.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f fpu_aux.f \
  --top-module fpu_aux_tb \
  -Mdir obj_dir -o fpu_aux_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/fpu_aux_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASS" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
